// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	localparam int data_width = 16;  // width of one operand word
	localparam int n_channels = 16;  // channel registers shared by all operands
	localparam int chan_addr_width = 4;  // enough to address every channel
	localparam int pending_width = 4;  // outstanding writes counted per channel
	localparam int commit_id_width = 9;
	localparam int n_operands = 3;  // operands a, b and c

	// half of full scale has only bit 14 set
	localparam logic [data_width - 1 : 0] half_scale_value = {2'b01, {(data_width - 2){1'b0}}};

	// the most negative value has only the sign bit set
	localparam logic [data_width - 1 : 0] min_value = {1'b1, {(data_width - 1){1'b0}}};

	// selector codes for register sourced operands, any other code reads zero
	typedef enum logic [chan_addr_width - 1 : 0] {
		sel_register_0 = 0,  // first block register
		sel_register_1 = 1,  // second block register
		sel_half_scale = 3,
		sel_min_value  = 4
	} reg_src_e;

	// opcodes are only carried through this stage to the execution stage
	typedef enum logic [4 : 0] {
		op_nop,
		op_add,
		op_sub,
		op_mul,
		op_mac
	} op_code_e;

	typedef enum logic [0 : 0] {
		fetch_idle,  // ready for a new instruction
		fetch_wait  // an instruction waits for a channel operand
	} fetch_state_e;

endpackage

`default_nettype wire

// ==== hw/operand_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one operand's view of the shared channel file and pending write tracker
interface operand_if;

	logic [fetch_pkg::chan_addr_width - 1 : 0] src;  // channel number or register selector
	logic from_reg;  // operand comes from a register or a constant
	logic needed;  // operand is used by the instruction at all
	logic signed [fetch_pkg::data_width - 1 : 0] read_value;  // stored word of channel src
	logic [fetch_pkg::pending_width - 1 : 0] pending;  // outstanding writes to channel src
	logic channel_write_hit;  // this cycle's channel write targets src

	modport resolver (
		output src, from_reg, needed,
		input read_value, pending, channel_write_hit
	);

	modport file (
		input src,
		output read_value
	);

	modport tracker (
		input src, from_reg, needed,
		output pending, channel_write_hit
	);

endinterface

`default_nettype wire

// ==== hw/channel_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_file (
	input logic clk,
	input logic reset,
	input logic channel_write_enable,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] channel_write_addr,
	input logic signed [fetch_pkg::data_width - 1 : 0] channel_write_val,
	operand_if.file ops [fetch_pkg::n_operands]
);

	logic signed [fetch_pkg::data_width - 1 : 0] channels [fetch_pkg::n_channels];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < fetch_pkg::n_channels; i++) begin
				channels[i] <= '0;
			end
		end else if (channel_write_enable) begin
			channels[channel_write_addr] <= channel_write_val;
		end
	end

	for (genvar i = 0; i < fetch_pkg::n_operands; i++) begin : g_read
		assign ops[i].read_value = channels[ops[i].src];
	end

endmodule

`default_nettype wire

// ==== hw/pending_write_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pending_write_tracker (
	input logic clk,
	input logic reset,
	input logic issue,  // a channel writing instruction enters the output register
	input logic [fetch_pkg::chan_addr_width - 1 : 0] issue_dest,
	input logic channel_write_enable,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] channel_write_addr,
	operand_if.tracker ops [fetch_pkg::n_operands]
);

	logic [fetch_pkg::pending_width - 1 : 0] counts [fetch_pkg::n_channels];  // writes still owed
	logic [fetch_pkg::n_channels - 1 : 0] issue_vec;  // one hot channel gaining a pending write
	logic [fetch_pkg::n_channels - 1 : 0] write_vec;  // one hot channel being written now

	assign issue_vec = {{(fetch_pkg::n_channels - 1){1'b0}}, issue} << issue_dest;
	assign write_vec = {{(fetch_pkg::n_channels - 1){1'b0}}, channel_write_enable}
		<< channel_write_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < fetch_pkg::n_channels; i++) begin
				counts[i] <= '0;
			end
		end else begin
			for (int i = 0; i < fetch_pkg::n_channels; i++) begin
				case ({issue_vec[i], write_vec[i]})
					2'b10: begin
						if (counts[i] != '1) begin  // saturate rather than wrap
							counts[i] <= counts[i] + 1'b1;
						end
					end
					2'b01: begin
						if (counts[i] != '0) begin  // a stray write never drives it negative
							counts[i] <= counts[i] - 1'b1;
						end
					end
					default: begin
						counts[i] <= counts[i];  // issue and write in one cycle cancel out
					end
				endcase
			end
		end
	end

	// report the count and the write match for each operand's channel
	for (genvar i = 0; i < fetch_pkg::n_operands; i++) begin : g_report
		assign ops[i].pending = counts[ops[i].src];
		assign ops[i].channel_write_hit = channel_write_enable
			&& ops[i].needed
			&& !ops[i].from_reg
			&& (channel_write_addr == ops[i].src);  // only channel operands can take a forward
	end

endmodule

`default_nettype wire

// ==== hw/operand_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_resolver (
	input logic clk,
	input logic reset,
	input logic capture,  // instruction accepted but not complete, latch the request
	input logic hold,  // stage is in the wait state
	input logic needed,
	input logic from_reg,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] src,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_0,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_1,
	input logic signed [fetch_pkg::data_width - 1 : 0] channel_write_val,
	operand_if.resolver port,
	output logic resolved,
	output logic signed [fetch_pkg::data_width - 1 : 0] value
);

	logic needed_q;
	logic from_reg_q;
	logic [fetch_pkg::chan_addr_width - 1 : 0] src_q;
	logic signed [fetch_pkg::data_width - 1 : 0] register_0_q;  // block registers seen at accept
	logic signed [fetch_pkg::data_width - 1 : 0] register_1_q;
	logic done_q;  // operand already resolved during this wait
	logic signed [fetch_pkg::data_width - 1 : 0] value_q;
	logic signed [fetch_pkg::data_width - 1 : 0] reg_value;
	logic signed [fetch_pkg::data_width - 1 : 0] now_value;
	logic channel_free;
	logic channel_forward;
	logic now_ok;
	logic evaluate;

	assign port.needed = hold ? needed_q : needed;  // live request while idle, latched while waiting
	assign port.from_reg = hold ? from_reg_q : from_reg;
	assign port.src = hold ? src_q : src;

	always_comb begin
		case (port.src)
			fetch_pkg::sel_register_0: reg_value = hold ? register_0_q : register_0;
			fetch_pkg::sel_register_1: reg_value = hold ? register_1_q : register_1;
			fetch_pkg::sel_half_scale: reg_value = fetch_pkg::half_scale_value;
			fetch_pkg::sel_min_value: reg_value = fetch_pkg::min_value;
			default: reg_value = '0;
		endcase
	end

	assign channel_free = (port.pending == '0);  // nothing outstanding, the stored word is current
	assign channel_forward = (port.pending == fetch_pkg::pending_width'(1))
		&& port.channel_write_hit;  // the last owed write arrives right now
	assign now_ok = !port.needed || port.from_reg || channel_free || channel_forward;

	always_comb begin
		if (!port.needed) begin
			now_value = '0;
		end else if (port.from_reg) begin
			now_value = reg_value;
		end else if (channel_free) begin
			now_value = port.read_value;
		end else begin
			now_value = channel_write_val;  // taken straight off the write port
		end
	end

	assign evaluate = capture || (hold && !done_q);  // accept cycle or still unresolved in wait
	assign resolved = (hold && done_q) || now_ok;
	assign value = (hold && done_q) ? value_q : now_value;

	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= 1'b0;
		end else if (evaluate) begin
			done_q <= now_ok;
		end else if (!hold) begin
			done_q <= 1'b0;  // idle again, nothing kept for the next instruction
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			needed_q <= needed;
			from_reg_q <= from_reg;
			src_q <= src;
			register_0_q <= register_0;
			register_1_q <= register_1;
		end
		if (evaluate && now_ok) begin
			value_q <= now_value;  // later channel writes cannot disturb it
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	input fetch_pkg::op_code_e operation_in,
	output fetch_pkg::op_code_e operation_out,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] dest_in,
	output logic [fetch_pkg::chan_addr_width - 1 : 0] dest_out,
	input logic writes_channel_in,
	output logic writes_channel_out,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_0_in,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_1_in,
	output logic signed [fetch_pkg::data_width - 1 : 0] register_0_out,
	output logic signed [fetch_pkg::data_width - 1 : 0] register_1_out,
	input logic operands_resolved,  // all three resolvers have a value this cycle
	input logic signed [fetch_pkg::data_width - 1 : 0] value_a,
	input logic signed [fetch_pkg::data_width - 1 : 0] value_b,
	input logic signed [fetch_pkg::data_width - 1 : 0] value_c,
	output logic signed [fetch_pkg::data_width - 1 : 0] arg_a,
	output logic signed [fetch_pkg::data_width - 1 : 0] arg_b,
	output logic signed [fetch_pkg::data_width - 1 : 0] arg_c,
	output logic [fetch_pkg::commit_id_width - 1 : 0] commit_id,
	output logic capture,
	output logic hold,
	output logic issue,
	output logic [fetch_pkg::chan_addr_width - 1 : 0] issue_dest
);

	fetch_pkg::fetch_state_e state;
	fetch_pkg::op_code_e operation_q;  // instruction fields kept while waiting
	logic [fetch_pkg::chan_addr_width - 1 : 0] dest_q;
	logic writes_channel_q;
	logic signed [fetch_pkg::data_width - 1 : 0] register_0_q;
	logic signed [fetch_pkg::data_width - 1 : 0] register_1_q;
	logic [fetch_pkg::commit_id_width - 1 : 0] commit_count;  // id for the next channel writer
	logic out_free;
	logic accept;
	logic load_wait;
	logic load;
	logic writes_channel_live;
	logic [fetch_pkg::chan_addr_width - 1 : 0] dest_live;

	assign out_free = !out_valid || out_ready;  // output register empty or draining this cycle
	assign in_ready = (state == fetch_pkg::fetch_idle) && out_free;
	assign accept = in_valid && in_ready;
	assign hold = (state == fetch_pkg::fetch_wait);
	assign capture = accept && !operands_resolved;  // some operand still awaits a write
	assign load_wait = hold && operands_resolved && out_free;
	assign load = (accept && operands_resolved) || load_wait;  // fast path or end of a wait

	assign writes_channel_live = hold ? writes_channel_q : writes_channel_in;
	assign dest_live = hold ? dest_q : dest_in;
	assign issue = load && writes_channel_live;  // the tracker counts this write from now on
	assign issue_dest = dest_live;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetch_pkg::fetch_idle;
			out_valid <= 1'b0;
			commit_count <= '0;
			commit_id <= '0;
		end else begin
			if (capture) begin
				state <= fetch_pkg::fetch_wait;
			end else if (load_wait) begin
				state <= fetch_pkg::fetch_idle;
			end
			if (load) begin
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;  // consumed and nothing new behind it
			end
			if (issue) begin
				commit_id <= commit_count;  // only channel writers take an id
				commit_count <= commit_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			operation_q <= operation_in;
			dest_q <= dest_in;
			writes_channel_q <= writes_channel_in;
			register_0_q <= register_0_in;
			register_1_q <= register_1_in;
		end
	end

	// output register, stable until the next stage takes it
	always_ff @(posedge clk) begin
		if (load) begin
			operation_out <= hold ? operation_q : operation_in;
			dest_out <= dest_live;
			writes_channel_out <= writes_channel_live;
			register_0_out <= hold ? register_0_q : register_0_in;
			register_1_out <= hold ? register_1_q : register_1_in;
			arg_a <= value_a;
			arg_b <= value_b;
			arg_c <= value_c;
		end
	end

endmodule

`default_nettype wire

// ==== hw/operand_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	input fetch_pkg::op_code_e operation_in,
	output fetch_pkg::op_code_e operation_out,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] dest_in,
	output logic [fetch_pkg::chan_addr_width - 1 : 0] dest_out,
	input logic writes_channel_in,
	output logic writes_channel_out,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_0_in,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_1_in,
	output logic signed [fetch_pkg::data_width - 1 : 0] register_0_out,
	output logic signed [fetch_pkg::data_width - 1 : 0] register_1_out,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] src_a,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] src_b,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] src_c,
	input logic from_reg_a,
	input logic from_reg_b,
	input logic from_reg_c,
	input logic needed_a,
	input logic needed_b,
	input logic needed_c,
	output logic signed [fetch_pkg::data_width - 1 : 0] arg_a,
	output logic signed [fetch_pkg::data_width - 1 : 0] arg_b,
	output logic signed [fetch_pkg::data_width - 1 : 0] arg_c,
	output logic [fetch_pkg::commit_id_width - 1 : 0] commit_id,
	input logic channel_write_enable,  // result write back from the execution stage
	input logic [fetch_pkg::chan_addr_width - 1 : 0] channel_write_addr,
	input logic signed [fetch_pkg::data_width - 1 : 0] channel_write_val
);

	logic [fetch_pkg::chan_addr_width - 1 : 0] src_vec [fetch_pkg::n_operands];  // index 0 is a
	logic [fetch_pkg::n_operands - 1 : 0] from_reg_vec;
	logic [fetch_pkg::n_operands - 1 : 0] needed_vec;
	logic [fetch_pkg::n_operands - 1 : 0] resolved_vec;
	logic signed [fetch_pkg::data_width - 1 : 0] value_vec [fetch_pkg::n_operands];
	logic operands_resolved;
	logic capture;
	logic hold;
	logic issue;
	logic [fetch_pkg::chan_addr_width - 1 : 0] issue_dest;

	operand_if op_bus [fetch_pkg::n_operands] ();  // one link per operand

	assign src_vec[0] = src_a;
	assign src_vec[1] = src_b;
	assign src_vec[2] = src_c;
	assign from_reg_vec = {from_reg_c, from_reg_b, from_reg_a};
	assign needed_vec = {needed_c, needed_b, needed_a};
	assign operands_resolved = &resolved_vec;  // the instruction moves only when all are ready

	channel_file u_channel_file (
		.clk(clk),
		.reset(reset),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.ops(op_bus)
	);

	pending_write_tracker u_tracker (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issue_dest(issue_dest),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.ops(op_bus)
	);

	for (genvar i = 0; i < fetch_pkg::n_operands; i++) begin : g_operand
		operand_resolver u_resolver (
			.clk(clk),
			.reset(reset),
			.capture(capture),
			.hold(hold),
			.needed(needed_vec[i]),
			.from_reg(from_reg_vec[i]),
			.src(src_vec[i]),
			.register_0(register_0_in),
			.register_1(register_1_in),
			.channel_write_val(channel_write_val),
			.port(op_bus[i]),
			.resolved(resolved_vec[i]),
			.value(value_vec[i])
		);
	end

	fetch_control u_control (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.operation_in(operation_in),
		.operation_out(operation_out),
		.dest_in(dest_in),
		.dest_out(dest_out),
		.writes_channel_in(writes_channel_in),
		.writes_channel_out(writes_channel_out),
		.register_0_in(register_0_in),
		.register_1_in(register_1_in),
		.register_0_out(register_0_out),
		.register_1_out(register_1_out),
		.operands_resolved(operands_resolved),
		.value_a(value_vec[0]),
		.value_b(value_vec[1]),
		.value_c(value_vec[2]),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.commit_id(commit_id),
		.capture(capture),
		.hold(hold),
		.issue(issue),
		.issue_dest(issue_dest)
	);

endmodule

`default_nettype wire

// ==== bench/fetch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input fetch_pkg::op_code_e operation_out,
	input logic [fetch_pkg::chan_addr_width - 1 : 0] dest_out,
	input logic writes_channel_out,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_0_out,
	input logic signed [fetch_pkg::data_width - 1 : 0] register_1_out,
	input logic signed [fetch_pkg::data_width - 1 : 0] arg_a,
	input logic signed [fetch_pkg::data_width - 1 : 0] arg_b,
	input logic signed [fetch_pkg::data_width - 1 : 0] arg_c,
	input logic [fetch_pkg::commit_id_width - 1 : 0] commit_id
);

	int unsigned failures = 0;  // assertion failures seen so far

	// a stalled output keeps every field until the next stage takes it
	stalled_output_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(operation_out) && $stable(dest_out)
			&& $stable(writes_channel_out) && $stable(register_0_out)
			&& $stable(register_1_out) && $stable(arg_a) && $stable(arg_b)
			&& $stable(arg_c) && $stable(commit_id))
		else begin
			failures++;
			$error("output changed while stalled");
		end

	no_accept_while_stalled: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |-> !in_ready)
		else begin
			failures++;
			$error("input side ready while the output is stalled");
		end

	// an accepted instruction is either output at once or keeps the input side closed
	waiting_blocks_input: assert property (@(posedge clk) disable iff (reset)
		in_valid && in_ready |=> out_valid || !in_ready)
		else begin
			failures++;
			$error("input side ready while an accepted instruction was neither output nor held");
		end

	reset_clears_output: assert property (@(posedge clk) reset |=> !out_valid)
		else begin
			failures++;
			$error("output valid right after reset");
		end

endmodule

bind operand_fetch_top fetch_checker checks (.*);

`default_nettype wire

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	localparam int n_instructions = 300;
	localparam int cycle_limit = 40 * n_instructions;  // worst case stalls stay far below this

	typedef struct packed {
		fetch_pkg::op_code_e operation;
		logic [fetch_pkg::chan_addr_width - 1 : 0] dest;
		logic writes_channel;
		logic [fetch_pkg::data_width - 1 : 0] register_0;
		logic [fetch_pkg::data_width - 1 : 0] register_1;
		logic [fetch_pkg::n_operands - 1 : 0][fetch_pkg::chan_addr_width - 1 : 0] src;
		logic [fetch_pkg::n_operands - 1 : 0] from_reg;
		logic [fetch_pkg::n_operands - 1 : 0] needed;
	} instr_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	fetch_pkg::op_code_e operation_in;
	fetch_pkg::op_code_e operation_out;
	logic [3:0] dest_in;
	logic [3:0] dest_out;
	logic writes_channel_in;
	logic writes_channel_out;
	logic signed [15:0] register_0_in;
	logic signed [15:0] register_1_in;
	logic signed [15:0] register_0_out;
	logic signed [15:0] register_1_out;
	logic [3:0] src_a;
	logic [3:0] src_b;
	logic [3:0] src_c;
	logic from_reg_a;
	logic from_reg_b;
	logic from_reg_c;
	logic needed_a;
	logic needed_b;
	logic needed_c;
	logic signed [15:0] arg_a;
	logic signed [15:0] arg_b;
	logic signed [15:0] arg_c;
	logic [8:0] commit_id;
	logic channel_write_enable;
	logic [3:0] channel_write_addr;
	logic signed [15:0] channel_write_val;

	integer seed = 32'h78a6;
	int cycle;  // cycles since reset was released
	int accepted_count;
	int output_count;
	int last_due;  // cycle of the latest scheduled write back
	logic accepted_now;  // the instruction on the input port was taken at the last edge
	logic fast_due;  // out_valid is judged at the next falling edge
	logic fast_expected;  // the last accepted instruction had every operand at hand
	logic [8:0] next_commit;  // commit id the next channel writer must carry
	logic [15:0] chan_model [16];  // channel contents as the execution stage left them
	int owed [16];  // writes taken by the execution stage and not yet performed
	instr_t current;  // instruction presented on the input port
	instr_t pending_q [$];  // accepted and not yet output, in program order
	int write_due_q [$];
	logic [3:0] write_addr_q [$];
	logic [15:0] write_val_q [$];

	assign operation_in = current.operation;
	assign dest_in = current.dest;
	assign writes_channel_in = current.writes_channel;
	assign register_0_in = current.register_0;
	assign register_1_in = current.register_1;
	assign src_a = current.src[0];
	assign src_b = current.src[1];
	assign src_c = current.src[2];
	assign from_reg_a = current.from_reg[0];
	assign from_reg_b = current.from_reg[1];
	assign from_reg_c = current.from_reg[2];
	assign needed_a = current.needed[0];
	assign needed_b = current.needed[1];
	assign needed_c = current.needed[2];

	operand_fetch_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic end_with_failure();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare(input string test, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (expected == actual) else begin
			$display("MISMATCH %s expected %0h actual %0h", test, expected, actual);
			end_with_failure();
		end
	endtask

	function automatic int unsigned draw(int unsigned range);
		return {$random(seed)} % range;
	endfunction

	// selector rule for register sourced operands
	function automatic logic [15:0] register_operand(logic [3:0] sel, logic [15:0] r0,
			logic [15:0] r1);
		case (sel)
			4'd0: return r0;
			4'd1: return r1;
			4'd3: return 16'h4000;  // half of full scale
			4'd4: return 16'h8000;  // full-scale negative
			default: return '0;
		endcase
	endfunction

	// a channel operand is at hand when no write to it is owed beyond the one arriving now
	function automatic logic resolvable_now(input instr_t ins);
		for (int k = 0; k < 3; k++) begin
			if (ins.needed[k] && !ins.from_reg[k] && owed[ins.src[k]] != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	function automatic instr_t random_instruction();
		instr_t ins;
		ins.operation = fetch_pkg::op_code_e'(5'(draw(5)));
		ins.dest = 4'(draw(8));  // eight channels keep read after write hazards frequent
		ins.writes_channel = (draw(2) == 0);
		ins.register_0 = 16'($random(seed));
		ins.register_1 = 16'($random(seed));
		for (int k = 0; k < 3; k++) begin
			ins.src[k] = 4'(draw(8));  // also hits the selector codes that read zero
			ins.from_reg[k] = (draw(5) < 2);
			ins.needed[k] = (draw(5) != 0);
		end
		return ins;
	endfunction

	// the execution stage performs writes in program order, one per cycle at most
	task automatic schedule_write(input logic [3:0] dest);
		int due;
		due = cycle + 1 + int'(draw(6));
		if (due <= last_due) begin
			due = last_due + 1;
		end
		last_due = due;
		owed[dest]++;
		write_due_q.push_back(due);
		write_addr_q.push_back(dest);
		write_val_q.push_back(16'($random(seed)));
	endtask

	task automatic check_output(input instr_t ins);
		logic [15:0] args [3];
		logic [15:0] expected;
		args[0] = arg_a;
		args[1] = arg_b;
		args[2] = arg_c;
		compare("operation order", 16'(ins.operation), 16'(operation_out));
		compare("dest", 16'(ins.dest), 16'(dest_out));
		compare("writes_channel", 16'(ins.writes_channel), 16'(writes_channel_out));
		compare("register_0", ins.register_0, register_0_out);
		compare("register_1", ins.register_1, register_1_out);
		for (int k = 0; k < 3; k++) begin
			if (!ins.needed[k]) begin
				compare("unused operand", 16'h0000, args[k]);
			end else if (ins.from_reg[k]) begin
				expected = register_operand(ins.src[k], ins.register_0, ins.register_1);
				compare("register operand", expected, args[k]);
			end else begin
				assert (owed[ins.src[k]] == 0) else begin
					$display("channel %0d was read before its pending write arrived", ins.src[k]);
					end_with_failure();
				end
				compare("channel operand", chan_model[ins.src[k]], args[k]);
			end
		end
		if (ins.writes_channel) begin
			compare("commit id", 16'(next_commit), 16'(commit_id));
			next_commit = next_commit + 1'b1;
			schedule_write(ins.dest);  // the result is owed from this edge on
		end
	endtask

	// handshake signals are settled at the falling edge, ahead of the edge that uses them
	task automatic observe_handshakes();
		if (dut.checks.failures != 0) begin
			$display("an assertion in the bound checker failed");
			end_with_failure();
		end
		if (fast_due) begin
			compare("fast path out_valid", 16'(fast_expected), 16'(out_valid));
			fast_due = 1'b0;
		end
		accepted_now = in_valid && in_ready;
		if (out_valid && out_ready) begin
			if (pending_q.size() == 0) begin
				$display("an output appeared with no accepted instruction behind it");
				end_with_failure();
			end
			check_output(pending_q.pop_front());
			output_count++;
		end
		if (accepted_now) begin
			fast_expected = resolvable_now(current);  // the output register is free on accept
			fast_due = 1'b1;
			pending_q.push_back(current);
			accepted_count++;
		end
	endtask

	task automatic drive_write_back();
		if (write_due_q.size() != 0 && write_due_q[0] <= cycle) begin
			channel_write_enable = 1'b1;
			channel_write_addr = write_addr_q.pop_front();
			channel_write_val = write_val_q.pop_front();
			void'(write_due_q.pop_front());
			chan_model[channel_write_addr] = channel_write_val;  // model follows the write at once
			owed[channel_write_addr]--;
		end else begin
			channel_write_enable = 1'b0;
		end
	endtask

	task automatic drive_stimulus();
		out_ready = (draw(10) < 7);  // random back-pressure from the next stage
		if (!in_valid || accepted_now) begin
			if (accepted_count < n_instructions && draw(4) != 0) begin
				current = random_instruction();
				in_valid = 1'b1;
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		out_ready = 1'b0;
		current = '0;
		channel_write_enable = 1'b0;
		channel_write_addr = '0;
		channel_write_val = '0;
		cycle = 0;
		accepted_count = 0;
		output_count = 0;
		last_due = 0;
		accepted_now = 1'b0;
		fast_due = 1'b0;
		fast_expected = 1'b0;
		next_commit = '0;
		for (int i = 0; i < 16; i++) begin
			chan_model[i] = '0;
			owed[i] = 0;
		end
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		while (output_count < n_instructions) begin
			@(negedge clk);
			observe_handshakes();
			@(posedge clk);
			#1;
			cycle++;
			if (cycle > cycle_limit) begin
				$display("timeout after %0d cycles with %0d of %0d instructions output",
					cycle, output_count, n_instructions);
				end_with_failure();
			end
			drive_write_back();
			drive_stimulus();
		end
		if (dut.checks.failures != 0) begin
			$display("an assertion in the bound checker failed");
			end_with_failure();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
hw/fetch_pkg.sv
hw/operand_if.sv
hw/channel_file.sv
hw/pending_write_tracker.sv
hw/operand_resolver.sv
hw/fetch_control.sv
hw/operand_fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
ERROR_LIMIT ?= 100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "run ended without a result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
